// File: verilog/exec_pkg.sv
package exec_pkg;

    // ==================================================
    // Widths
    // ==================================================

    // RV32 data path
    localparam int XLEN      = 32;
    // Reorder-buffer tag
    localparam int TAG_WIDTH = 6;

    // ==================================================
    // Operation encodings
    // ==================================================

    // Integer operation select
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        SLT    = 4'd8,
        SLTU   = 4'd9,
        // LUI passes the immediate through
        PASS_B = 4'd10
    } alu_op_e;

    // Branch kind, no BGEU so the field fits in 3 bits
    typedef enum logic [2:0] {
        NONE = 3'd0,
        BEQ  = 3'd1,
        BNE  = 3'd2,
        BLT  = 3'd3,
        BGE  = 3'd4,
        BLTU = 3'd5,
        JAL  = 3'd6,
        JALR = 3'd7
    } branch_sel_e;

    // ==================================================
    // Bundles
    // ==================================================

    // Condition flags taken from the subtract path
    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } alu_flags_t;

    // One operation from a reservation station
    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        alu_op_e              alu_op;
        branch_sel_e          branch_sel;
        logic [XLEN-1:0]      operand_a;
        logic [XLEN-1:0]      operand_b;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      branch_target;
        logic                 predicted_taken;
        logic [XLEN-1:0]      predicted_pc;
        // Load or store address calculation
        logic                 mem_addr;
    } issue_op_t;

    // Common data bus broadcast
    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        logic [XLEN-1:0]      value;
        logic                 is_branch;
        logic                 mispredict;
        logic [XLEN-1:0]      correct_pc;
        logic                 mem_addr;
    } cdb_t;

    // Branch outcome handed from resolver to unit
    typedef struct packed {
        logic            is_branch;
        logic            mispredict;
        logic [XLEN-1:0] correct_pc;
    } branch_out_t;

endpackage

// File: verilog/alu_shifter.sv
`timescale 1ns/1ps

module alu_shifter (
    input  logic [exec_pkg::XLEN-1:0] a,
    input  logic [exec_pkg::XLEN-1:0] b,
    input  exec_pkg::alu_op_e         alu_op,
    output logic [exec_pkg::XLEN-1:0] result,
    output exec_pkg::alu_flags_t      flags
);
    import exec_pkg::*;

    // Adder paths
    logic [XLEN:0]   sub_full;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] sum;
    logic            lt_signed;
    logic            lt_unsigned;

    // Barrel shifter, right shifting only
    logic [4:0]      shamt;
    logic            shift_fill;
    logic [XLEN-1:0] shift_stage [6];
    logic [XLEN-1:0] shift_out;

    // Mirror a word so a left shift can reuse the right shifter
    function automatic logic [XLEN-1:0] bit_reverse(input logic [XLEN-1:0] v);
        logic [XLEN-1:0] r;
        for (int i = 0; i < XLEN; i++) begin
            r[i] = v[XLEN-1-i];
        end
        return r;
    endfunction

    // ==================================================
    // Add and subtract
    // ==================================================

    assign sum = a + b;

    // a + ~b + 1, the top bit is the carry (no borrow)
    assign sub_full = {1'b0, a} + {1'b0, ~b} + {{XLEN{1'b0}}, 1'b1};
    assign diff     = sub_full[XLEN-1:0];

    // Flags always describe a - b
    assign flags.zero     = (diff == '0);
    assign flags.negative = diff[XLEN-1];
    assign flags.carry    = sub_full[XLEN];
    assign flags.overflow = (a[XLEN-1] ^ b[XLEN-1]) & (a[XLEN-1] ^ diff[XLEN-1]);

    // Comparisons come straight off the flags
    assign lt_signed   = flags.negative ^ flags.overflow;
    assign lt_unsigned = ~flags.carry;

    // ==================================================
    // Shifter
    // ==================================================

    // Only the low five bits of b count
    assign shamt      = b[4:0];
    // Sign fill for SRA only
    assign shift_fill = (alu_op == SRA) & a[XLEN-1];

    assign shift_stage[0] = (alu_op == SLL) ? bit_reverse(a) : a;

    // One stage per shift amount bit
    for (genvar s = 0; s < 5; s++) begin : g_shift
        localparam int STEP = 1 << s;
        assign shift_stage[s+1] = shamt[s]
            ? {{STEP{shift_fill}}, shift_stage[s][XLEN-1:STEP]}
            : shift_stage[s];
    end

    assign shift_out = shift_stage[5];

    // Result select
    always_comb begin
        case (alu_op)
            ADD:     result = sum;
            SUB:     result = diff;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            // Undo the mirror on the way out
            SLL:     result = bit_reverse(shift_out);
            SRL:     result = shift_out;
            SRA:     result = shift_out;
            SLT:     result = {{(XLEN-1){1'b0}}, lt_signed};
            SLTU:    result = {{(XLEN-1){1'b0}}, lt_unsigned};
            PASS_B:  result = b;
            default: result = '0;
        endcase
    end

endmodule

// File: verilog/branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver (
    input  exec_pkg::issue_op_t       op,
    input  logic [exec_pkg::XLEN-1:0] alu_result,
    input  exec_pkg::alu_flags_t      flags,
    output exec_pkg::branch_out_t     br
);
    import exec_pkg::*;

    logic            taken;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] jalr_target;

    // Fall-through address
    assign pc_plus4 = op.pc + XLEN'(4);

    // ALU runs ADD for JALR, drop the two low bits
    assign jalr_target = {alu_result[XLEN-1:2], 2'b00};

    // Condition from the a - b flags
    always_comb begin
        case (op.branch_sel)
            BEQ:     taken = flags.zero;
            BNE:     taken = !flags.zero;
            BLT:     taken = flags.negative ^ flags.overflow;
            BGE:     taken = !(flags.negative ^ flags.overflow);
            // No borrow means a >= b unsigned
            BLTU:    taken = !flags.carry;
            default: taken = 1'b0;
        endcase
    end

    // ==================================================
    // Outcome and redirect
    // ==================================================

    always_comb begin
        br.is_branch  = (op.branch_sel != NONE);
        br.mispredict = 1'b0;
        br.correct_pc = pc_plus4;
        case (op.branch_sel)
            // Plain op, next PC is sequential
            NONE: br.correct_pc = pc_plus4;
            // Target is known at decode so never wrong
            JAL:  br.correct_pc = op.branch_target;
            JALR: begin
                br.mispredict = (jalr_target != op.predicted_pc);
                br.correct_pc = jalr_target;
            end
            default: begin
                br.mispredict = taken ^ op.predicted_taken;
                br.correct_pc = taken ? op.branch_target : pc_plus4;
            end
        endcase
    end

endmodule

// File: verilog/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue_valid,
    input  exec_pkg::issue_op_t issue_op,
    output logic                issue_ready,
    output logic                pending,
    output exec_pkg::cdb_t      result,
    input  logic                grant
);
    import exec_pkg::*;

    alu_op_e         eff_op;
    logic [XLEN-1:0] alu_result;
    alu_flags_t      alu_flags;
    branch_out_t     br;
    logic [XLEN-1:0] link_addr;
    cdb_t            next_result;
    logic            fire;

    // ==================================================
    // Issue handshake
    // ==================================================

    // Accept when empty, or when the held result leaves this cycle
    assign issue_ready = !pending || grant;
    assign fire        = issue_valid && issue_ready;

    // ALU op override for branches and address math
    always_comb begin
        eff_op = issue_op.alu_op;
        if (issue_op.mem_addr || issue_op.branch_sel == JALR) begin
            eff_op = ADD;
        end else if (issue_op.branch_sel inside {BEQ, BNE, BLT, BGE, BLTU}) begin
            // Compare through the subtract path
            eff_op = SUB;
        end
    end

    alu_shifter i_alu_shifter (
        .a      (issue_op.operand_a),
        .b      (issue_op.operand_b),
        .alu_op (eff_op),
        .result (alu_result),
        .flags  (alu_flags)
    );

    branch_resolver i_branch_resolver (
        .op         (issue_op),
        .alu_result (alu_result),
        .flags      (alu_flags),
        .br         (br)
    );

    // Return address for JAL and JALR
    assign link_addr = issue_op.pc + XLEN'(4);

    // ==================================================
    // Result formation
    // ==================================================

    always_comb begin
        next_result.tag        = issue_op.tag;
        next_result.is_branch  = br.is_branch;
        next_result.mispredict = br.mispredict;
        next_result.correct_pc = br.correct_pc;
        next_result.mem_addr   = issue_op.mem_addr;
        case (issue_op.branch_sel)
            // ALU result, address sum for loads and stores
            NONE:      next_result.value = alu_result;
            JAL, JALR: next_result.value = link_addr;
            // Conditional branches write nothing
            default:   next_result.value = '0;
        endcase
    end

    // Pending flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (fire) begin
            // New op refills even when the old one is granted
            pending <= 1'b1;
        end else if (grant) begin
            pending <= 1'b0;
        end
    end

    // Held output register
    always_ff @(posedge clk) begin
        if (fire) begin
            result <= next_result;
        end
    end

endmodule

// File: verilog/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter #(
    parameter int NUM_FU = 3
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [NUM_FU-1:0]           pending,
    input  exec_pkg::cdb_t [NUM_FU-1:0] results,
    output logic [NUM_FU-1:0]           grant,
    output logic                        cdb_valid,
    output exec_pkg::cdb_t              cdb
);

    localparam int PTR_W = (NUM_FU > 1) ? $clog2(NUM_FU) : 1;

    // Unit with the highest priority this cycle
    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] grant_idx;
    logic             hit;

    // ==================================================
    // Round-robin search
    // ==================================================

    always_comb begin
        int unsigned idx;
        hit       = 1'b0;
        grant     = '0;
        grant_idx = ptr;
        for (int k = 0; k < NUM_FU; k++) begin
            // Walk from the pointer and wrap
            idx = int'(ptr) + k;
            if (idx >= NUM_FU) begin
                idx = idx - NUM_FU;
            end
            if (!hit && pending[idx]) begin
                hit        = 1'b1;
                grant[idx] = 1'b1;
                grant_idx  = PTR_W'(idx);
            end
        end
    end

    // Bus driven straight from the granted register
    assign cdb_valid = hit;
    assign cdb       = hit ? results[grant_idx] : '0;

    // Pointer moves one past the winner
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (hit) begin
            if (grant_idx == PTR_W'(NUM_FU - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= grant_idx + PTR_W'(1);
            end
        end
    end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
    parameter int NUM_FU = 3
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [NUM_FU-1:0]                issue_valid,
    input  exec_pkg::issue_op_t [NUM_FU-1:0] issue_op,
    output logic [NUM_FU-1:0]                issue_ready,
    output logic                             cdb_valid,
    output exec_pkg::cdb_t                   cdb
);
    import exec_pkg::*;

    // Per-unit hold state toward the arbiter
    logic [NUM_FU-1:0]  unit_pending;
    logic [NUM_FU-1:0]  unit_grant;
    cdb_t [NUM_FU-1:0]  unit_result;

    // ==================================================
    // Functional units
    // ==================================================

    // One unit per reservation-station port
    for (genvar i = 0; i < NUM_FU; i++) begin : g_fu
        exec_unit i_exec_unit (
            .clk         (clk),
            .rst_n       (rst_n),
            .issue_valid (issue_valid[i]),
            .issue_op    (issue_op[i]),
            .issue_ready (issue_ready[i]),
            .pending     (unit_pending[i]),
            .result      (unit_result[i]),
            .grant       (unit_grant[i])
        );
    end

    // ==================================================
    // CDB arbitration
    // ==================================================

    // One broadcast per cycle
    cdb_arbiter #(
        .NUM_FU (NUM_FU)
    ) i_cdb_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .pending   (unit_pending),
        .results   (unit_result),
        .grant     (unit_grant),
        .cdb_valid (cdb_valid),
        .cdb       (cdb)
    );

endmodule

// File: bench/execute_stage_checker.sv
`timescale 1ns/1ps

module execute_stage_checker #(
    parameter int NUM_FU = 3
) (
    input logic                             clk,
    input logic                             rst_n,
    input logic [NUM_FU-1:0]                issue_valid,
    input exec_pkg::issue_op_t [NUM_FU-1:0] issue_op,
    input logic [NUM_FU-1:0]                issue_ready,
    input logic                             cdb_valid,
    input exec_pkg::cdb_t                   cdb
);

    // ==================================================
    // Issue handshake
    // ==================================================

    // A stalled op must not change under the unit
    for (genvar i = 0; i < NUM_FU; i++) begin : g_port
        a_op_stable : assert property (@(posedge clk) disable iff (!rst_n)
            issue_valid[i] && !issue_ready[i] |=> $stable(issue_op[i]))
            else $error("issue_op changed while valid was high and ready low");
    end

    // ==================================================
    // CDB
    // ==================================================

    // Bus stays quiet through reset
    a_cdb_reset : assert property (@(posedge clk)
        !rst_n |=> !cdb_valid)
        else $error("cdb_valid high during reset");

    // Same tag twice in a row means a result was sent again
    a_tag_repeat : assert property (@(posedge clk) disable iff (!rst_n)
        cdb_valid && $past(cdb_valid) |-> cdb.tag != $past(cdb.tag))
        else $error("tag repeated on consecutive CDB cycles");

endmodule

bind execute_stage execute_stage_checker #(
    .NUM_FU (NUM_FU)
) i_execute_stage_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_ready (issue_ready),
    .cdb_valid   (cdb_valid),
    .cdb         (cdb)
);

// File: bench/tb_execute_stage.sv
`timescale 1ns/1ps

module tb_execute_stage;
    import exec_pkg::*;

    localparam int NUM_FU   = 3;
    localparam int NUM_TAGS = 2 ** TAG_WIDTH;

    // Op counts per test
    localparam int N_ALU       = 71;
    localparam int N_BRANCH    = 50;
    localparam int N_JUMP      = 20;
    localparam int N_MEM       = 12;
    localparam int N_STRESS    = 90;
    localparam int TOTAL_OPS   = N_ALU + N_BRANCH + N_JUMP + N_MEM + N_STRESS;
    localparam int CYCLE_LIMIT = 20 * TOTAL_OPS + 200;

    // Branch operand pairs: equal, less, greater, then the two sign-boundary cases
    localparam logic [4:0][XLEN-1:0] BR_A = {32'd7, 32'd1, 32'd5, 32'hffff_ffff, 32'd1};
    localparam logic [4:0][XLEN-1:0] BR_B = {32'd7, 32'd2, 32'd3, 32'd1, 32'hffff_ffff};

    logic                   clk;
    logic                   rst_n;
    logic [NUM_FU-1:0]      issue_valid;
    issue_op_t [NUM_FU-1:0] issue_op;
    logic [NUM_FU-1:0]      issue_ready;
    logic                   cdb_valid;
    cdb_t                   cdb;

    // Scoreboard by tag
    issue_op_t            op_q[$];
    cdb_t                 exp_tab [NUM_TAGS];
    bit                   exp_valid [NUM_TAGS];
    bit                   retired [NUM_TAGS];
    logic [TAG_WIDTH-1:0] next_tag;
    bit [NUM_FU-1:0]      fired;
    bit                   gaps;
    int                   low_cnt [NUM_FU];
    int                   accepted;
    int                   seen;
    int                   checks;
    int                   errors;
    int                   cycles;

    execute_stage #(
        .NUM_FU (NUM_FU)
    ) i_execute_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_ready (issue_ready),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb)
    );

    always #4 clk = ~clk;

    // ==================================================
    // Reference model
    // ==================================================

    function automatic cdb_t expected_cdb(input issue_op_t op);
        cdb_t            e;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] pc4;
        logic [XLEN-1:0] target;
        logic            taken;
        a        = op.operand_a;
        b        = op.operand_b;
        pc4      = op.pc + 32'd4;
        target   = (a + b) & 32'hffff_fffc;
        e.tag        = op.tag;
        e.mem_addr   = op.mem_addr;
        e.is_branch  = (op.branch_sel != NONE);
        e.mispredict = 1'b0;
        e.correct_pc = pc4;
        case (op.alu_op)
            ADD:     e.value = a + b;
            SUB:     e.value = a - b;
            AND:     e.value = a & b;
            OR:      e.value = a | b;
            XOR:     e.value = a ^ b;
            SLL:     e.value = a << b[4:0];
            SRL:     e.value = a >> b[4:0];
            SRA:     e.value = $unsigned($signed(a) >>> b[4:0]);
            SLT:     e.value = XLEN'($signed(a) < $signed(b));
            SLTU:    e.value = XLEN'(a < b);
            PASS_B:  e.value = b;
            default: e.value = '0;
        endcase
        case (op.branch_sel)
            // Address math is a plain sum
            NONE: if (op.mem_addr) e.value = a + b;
            JAL: begin
                e.value      = pc4;
                e.correct_pc = op.branch_target;
            end
            JALR: begin
                e.value      = pc4;
                e.correct_pc = target;
                e.mispredict = (target != op.predicted_pc);
            end
            default: begin
                case (op.branch_sel)
                    BEQ:     taken = (a == b);
                    BNE:     taken = (a != b);
                    BLT:     taken = ($signed(a) < $signed(b));
                    BGE:     taken = ($signed(a) >= $signed(b));
                    BLTU:    taken = (a < b);
                    default: taken = 1'b0;
                endcase
                e.value      = '0;
                e.mispredict = taken ^ op.predicted_taken;
                e.correct_pc = taken ? op.branch_target : pc4;
            end
        endcase
        return e;
    endfunction

    // Op with word-aligned random PC and target, tag set at issue
    function automatic issue_op_t build_op(input alu_op_e aop, input branch_sel_e sel,
                                           input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                           input logic mem, input logic pred_taken,
                                           input logic [XLEN-1:0] pred_pc);
        issue_op_t op;
        op.tag             = '0;
        op.alu_op          = aop;
        op.branch_sel      = sel;
        op.operand_a       = a;
        op.operand_b       = b;
        op.pc              = $urandom() & 32'hffff_fffc;
        op.branch_target   = $urandom() & 32'hffff_fffc;
        op.predicted_taken = pred_taken;
        op.predicted_pc    = pred_pc;
        op.mem_addr        = mem;
        return op;
    endfunction

    task automatic report_value(input string sig, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        $display("[ERROR] %s got %h expected %h", sig, got, exp);
        errors++;
    endtask

    // Wait for the queue and the CDB to drain, then report the test
    task automatic run_test(input string name, input int n_ops);
        int err0;
        err0 = errors;
        while (op_q.size() != 0 || issue_valid != '0 || accepted != seen) begin
            @(negedge clk);
        end
        $display("test %-8s ops %3d errors %0d", name, n_ops, errors - err0);
    endtask

    // ==================================================
    // Stimulus, compare and timeout
    // ==================================================

    always @(negedge clk) begin : drive
        issue_op_t op;
        if (!rst_n) begin
            fired = '0;
        end else begin
            for (int i = 0; i < NUM_FU; i++) begin
                // Hold a stalled op, otherwise load the next one
                if (!issue_valid[i] || fired[i]) begin
                    issue_valid[i] = 1'b0;
                    if (op_q.size() != 0 && !(gaps && ((cycles + i) % 3 == 0))) begin
                        op     = op_q.pop_front();
                        op.tag = next_tag;
                        if (exp_valid[next_tag]) begin
                            $display("tag %0h reissued while its result is still out", next_tag);
                            errors++;
                        end
                        next_tag       = next_tag + TAG_WIDTH'(1);
                        issue_op[i]    = op;
                        issue_valid[i] = 1'b1;
                    end
                end
            end
            // Ready does not depend on valid, so this predicts the next edge
            for (int i = 0; i < NUM_FU; i++) begin
                fired[i] = issue_valid[i] && issue_ready[i];
                if (fired[i]) begin
                    exp_tab[issue_op[i].tag]   = expected_cdb(issue_op[i]);
                    exp_valid[issue_op[i].tag] = 1'b1;
                    retired[issue_op[i].tag]   = 1'b0;
                    accepted++;
                end
            end
        end
    end

    always @(negedge clk) begin : compare
        cdb_t                 e;
        logic [TAG_WIDTH-1:0] t;
        if (rst_n) begin
            // Stall watch per port
            for (int i = 0; i < NUM_FU; i++) begin
                low_cnt[i] = issue_ready[i] ? 0 : low_cnt[i] + 1;
                if (low_cnt[i] > NUM_FU) begin
                    $display("issue_ready of port %0d low for over %0d cycles", i, NUM_FU);
                    errors++;
                    low_cnt[i] = 0;
                end
            end
            if (cdb_valid) begin
                t = cdb.tag;
                if (!exp_valid[t]) begin
                    if (retired[t]) $display("tag %0h broadcast again after it retired", t);
                    else $display("tag %0h broadcast but never accepted", t);
                    errors++;
                end else begin
                    e = exp_tab[t];
                    checks++;
                    if (cdb.value !== e.value)
                        report_value($sformatf("cdb.value tag %0h", t), cdb.value, e.value);
                    if (cdb.is_branch !== e.is_branch)
                        report_value($sformatf("cdb.is_branch tag %0h", t),
                                     XLEN'(cdb.is_branch), XLEN'(e.is_branch));
                    if (cdb.mispredict !== e.mispredict)
                        report_value($sformatf("cdb.mispredict tag %0h", t),
                                     XLEN'(cdb.mispredict), XLEN'(e.mispredict));
                    if (cdb.mem_addr !== e.mem_addr)
                        report_value($sformatf("cdb.mem_addr tag %0h", t),
                                     XLEN'(cdb.mem_addr), XLEN'(e.mem_addr));
                    if (e.is_branch && cdb.correct_pc !== e.correct_pc)
                        report_value($sformatf("cdb.correct_pc tag %0h", t),
                                     cdb.correct_pc, e.correct_pc);
                    exp_valid[t] = 1'b0;
                    retired[t]   = 1'b1;
                    seen++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with results still outstanding", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] aligned;
        branch_sel_e     sel;
        void'($urandom(37520));
        clk         = 1'b0;
        rst_n       = 1'b0;
        issue_valid = '0;
        issue_op    = '0;
        next_tag    = '0;
        gaps        = 1'b1;
        repeat (8) @(negedge clk);

        // Idle state out of reset
        if (cdb_valid !== 1'b0) report_value("cdb_valid", XLEN'(cdb_valid), 32'd0);
        if (issue_ready !== '1) report_value("issue_ready", XLEN'(issue_ready), XLEN'(3'b111));
        rst_n = 1'b1;
        $display("test %-8s ops %3d errors %0d", "reset", 0, errors);

        // Every op select in turn, then sign-boundary cases
        for (int k = 0; k < N_ALU - 5; k++) begin
            op_q.push_back(build_op(alu_op_e'(4'(k % 11)), NONE, $urandom(), $urandom(),
                                    1'b0, 1'b0, '0));
        end
        op_q.push_back(build_op(SRA, NONE, 32'h8000_0000, 32'd31, 1'b0, 1'b0, '0));
        op_q.push_back(build_op(SLT, NONE, 32'h8000_0000, 32'h7fff_ffff, 1'b0, 1'b0, '0));
        op_q.push_back(build_op(SLTU, NONE, 32'h8000_0000, 32'h7fff_ffff, 1'b0, 1'b0, '0));
        op_q.push_back(build_op(SLT, NONE, 32'h7fff_ffff, 32'h8000_0000, 1'b0, 1'b0, '0));
        op_q.push_back(build_op(SLTU, NONE, 32'h7fff_ffff, 32'h8000_0000, 1'b0, 1'b0, '0));
        run_test("alu", N_ALU);

        // Each kind, each prediction, each operand pair
        for (int s = 1; s <= 5; s++) begin
            for (int p = 0; p < 2; p++) begin
                for (int k = 0; k < 5; k++) begin
                    op_q.push_back(build_op(ADD, branch_sel_e'(3'(s)), BR_A[k], BR_B[k],
                                            1'b0, 1'(p), '0));
                end
            end
        end
        run_test("branch", N_BRANCH);

        // JALR predicted right on even k, off by a word on odd k
        for (int k = 0; k < N_JUMP / 2; k++) begin
            a       = $urandom();
            b       = $urandom();
            aligned = (a + b) & 32'hffff_fffc;
            op_q.push_back(build_op(ADD, JAL, a, b, 1'b0, 1'($urandom()), $urandom()));
            op_q.push_back(build_op(ADD, JALR, a, b, 1'b0, 1'b0,
                                    (k % 2 == 0) ? aligned : aligned + 32'd4));
        end
        run_test("jump", N_JUMP);

        // Random op select, the unit must still add
        for (int k = 0; k < N_MEM; k++) begin
            op_q.push_back(build_op(alu_op_e'(4'($urandom_range(10, 0))), NONE,
                                    $urandom(), $urandom(), 1'b1, 1'b0, '0));
        end
        run_test("mem", N_MEM);

        // All ports busy every cycle with a random mix
        gaps = 1'b0;
        for (int k = 0; k < N_STRESS; k++) begin
            sel     = branch_sel_e'(3'($urandom_range(7, 0)));
            a       = $urandom();
            b       = $urandom();
            aligned = (a + b) & 32'hffff_fffc;
            op_q.push_back(build_op(alu_op_e'(4'($urandom_range(10, 0))), sel, a, b,
                                    (sel == NONE) && (k % 4 == 0), 1'($urandom()),
                                    1'($urandom()) ? aligned : $urandom()));
        end
        run_test("stress", N_STRESS);

        // Anything still outstanding was lost
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (exp_valid[t]) begin
                $display("tag %0h was accepted but never appeared on the CDB", t);
                errors++;
            end
        end
        if (accepted != TOTAL_OPS) begin
            $display("only %0d of %0d ops were accepted", accepted, TOTAL_OPS);
            errors++;
        end
        $display("ops %0d accepted %0d broadcast %0d checks %0d errors %0d",
                 TOTAL_OPS, accepted, seen, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
verilog/exec_pkg.sv
verilog/alu_shifter.sv
verilog/branch_resolver.sv
verilog/exec_unit.sv
verilog/cdb_arbiter.sv
verilog/execute_stage.sv
bench/execute_stage_checker.sv
bench/tb_execute_stage.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_execute_stage
FILELIST := list.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
